//--- src.f
hdl/stream_pack_pkg.sv
hdl/stream_pack_count.sv
hdl/stream_pack_compact.sv
hdl/stream_pack_merge.sv
hdl/stream_pack.sv
tests/stream_pack_tb.sv

//--- Makefile
# Verilator build and run for the AXI4-Stream byte packer.
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = stream_pack_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_TEXT = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message is in the simulator output.
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/stream_pack_tb.sv
// byte packer testbench top with clock, reset, LFSR stimulus, byte-queue model and assertions.
module stream_pack_tb import stream_pack_pkg::*; ();

    localparam int          beat_total      = 600;    // input beats in the random run.
    localparam int          handshake_limit = 64;     // cycles a beat may wait for rx_ready.
    localparam int          drain_limit     = 20;     // cycles to empty the model at the end.
    localparam logic [15:0] lfsr_seed       = 16'd37;

    // one model entry holding a kept byte or the end of a packet.
    typedef struct packed {
        logic                  marker;                // packet end with data unused.
        logic [byte_width-1:0] data;                  // expected output byte.
    } model_entry_t;

    logic         aclk = 1'b0;
    logic         areset_n;
    stream_beat_t rx_beat;
    logic         rx_valid;
    logic         rx_ready;
    stream_beat_t tx_beat;
    logic         tx_valid;
    logic         tx_ready;

    logic [15:0]  lfsr_state;                         // Fibonacci LFSR with x^16+x^14+x^13+x^11+1.
    model_entry_t model_q[$];                         // bytes and packet ends still owed.
    logic         draining;                           // stimulus over and tx_ready forced high.
    logic         reset_seen;                         // reset was low at the last falling edge.
    logic         stall_seen;                         // output beat was held at the last edge.
    stream_beat_t stall_beat;                         // beat that must still be on tx_beat.

    stream_pack dut (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_beat  (rx_beat),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_beat  (tx_beat),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    always #10 aclk = ~aclk;                          // period of 20.

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_value(input string test_name, input logic [63:0] expected,
                                input logic [63:0] actual);
        $display("Error %s: expected %0h, actual %0h", test_name, expected, actual);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // one LFSR step that returns the new bit.
    function automatic logic shift_lfsr();
        logic feedback;

        feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    // count fresh LFSR bits with one step per bit.
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;

        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], shift_lfsr()};
        end
        return value;
    endfunction

    // advance to just after the next rising edge and pick tx_ready.
    task automatic next_cycle();
        @(posedge aclk);
        #1;
        tx_ready = draining || (random_bits(2) != 0); // low about one cycle in four.
    endtask

    // present a beat and hold it until rx_ready takes it.
    task automatic send_beat(input stream_beat_t beat);
        int   waited;
        logic taken;

        rx_beat  = beat;
        rx_valid = 1'b1;
        waited   = 0;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge aclk);
            taken = rx_ready;                         // transfer happens at the coming edge.
            next_cycle();
            waited++;
            if (!taken && waited >= handshake_limit) begin
                report_failure("timeout: rx_ready stayed low while an input beat waited");
            end
        end
        rx_valid = 1'b0;
    endtask

    // kept bytes in lane order and a packet end on tlast.
    task automatic record_input();
        for (int i = 0; i < data_bytes; i++) begin
            if (rx_beat.tkeep[i]) begin
                model_q.push_back('{marker: 1'b0, data: rx_beat.tdata[i]});
            end
        end
        if (rx_beat.tlast) begin
            model_q.push_back('{marker: 1'b1, data: '0});
        end
    endtask

    task automatic check_output();
        logic [data_bytes-1:0] keep_next;             // tkeep plus one.

        if (!tx_beat.tlast) begin
            assert (tx_beat.tkeep == '1)
                else report_value("dense_beats", {data_bytes{1'b1}}, tx_beat.tkeep);
        end else begin
            keep_next = tx_beat.tkeep + {{(data_bytes-1){1'b0}}, 1'b1};
            assert ((tx_beat.tkeep & keep_next) == '0)  // no overlap only for low ones.
                else report_failure("last_beat: tkeep of a tlast beat is not contiguous");
        end
        for (int i = 0; i < data_bytes; i++) begin
            if (tx_beat.tkeep[i]) begin
                assert (model_q.size() != 0 && !model_q[0].marker)
                    else report_failure("byte_order: output byte has no input byte to match");
                assert (model_q[0].data == tx_beat.tdata[i])
                    else report_value("byte_order", model_q[0].data, tx_beat.tdata[i]);
                void'(model_q.pop_front());
            end
        end
        if (tx_beat.tlast) begin                      // last byte must close a packet.
            assert (model_q.size() != 0 && model_q[0].marker)
                else report_failure("last_beat: tlast came out before its packet ended");
            void'(model_q.pop_front());
        end
    endtask

    // outputs and handshakes are stable at the falling edge.
    always @(negedge aclk) begin
        if (!areset_n || reset_seen) begin
            assert (!tx_valid) else report_value("reset_idle", 0, tx_valid);
        end
        reset_seen = !areset_n;
        if (areset_n) begin
            if (stall_seen) begin
                assert (tx_valid)
                    else report_failure("backpressure_hold: tx_valid dropped under back-pressure");
                assert (tx_beat == stall_beat)
                    else report_value("backpressure_hold", stall_beat, tx_beat);
            end
            stall_seen = tx_valid && !tx_ready;
            stall_beat = tx_beat;
            if (tx_valid && tx_ready) begin
                check_output();
            end
            if (rx_valid && rx_ready) begin
                record_input();
            end
        end
    end

    initial begin
        stream_beat_t beat;
        int           drain_wait;

        areset_n    = 1'b0;
        rx_beat     = '0;
        rx_valid    = 1'b0;
        tx_ready    = 1'b0;
        lfsr_state  = lfsr_seed;
        draining    = 1'b0;
        reset_seen  = 1'b0;
        stall_seen  = 1'b0;
        stall_beat  = '0;
        repeat (8) @(posedge aclk);                   // reset held for 8 cycles.
        #1;
        areset_n = 1'b1;
        tx_ready = 1'b1;

        for (int n = 0; n < beat_total; n++) begin
            if (random_bits(2) == 0) begin
                next_cycle();                         // idle gap on rx_valid.
            end
            beat.tdata = random_bits(32);
            if (random_bits(3) == 0) begin
                beat.tkeep = '0;                      // null beat so that empty packets occur.
            end else begin
                beat.tkeep = data_bytes'(random_bits(data_bytes));
            end
            beat.tlast = (random_bits(3) == 0) || (n == beat_total - 1);
            send_beat(beat);
        end

        // every owed byte and packet end must leave and the output must go idle.
        draining   = 1'b1;
        tx_ready   = 1'b1;
        drain_wait = 0;
        while (model_q.size() != 0 || tx_valid) begin
            next_cycle();
            drain_wait++;
            if ((model_q.size() != 0 || tx_valid) && drain_wait >= drain_limit) begin
                report_failure("drain: output not drained 20 cycles after the stimulus");
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

//--- hdl/stream_pack.sv
// top level of the AXI4-Stream byte packer that chains count, compact and merge.
module stream_pack import stream_pack_pkg::*; (
    input  logic         aclk,
    input  logic         areset_n,
    input  stream_beat_t rx_beat,
    input  logic         rx_valid,
    output logic         rx_ready,
    output stream_beat_t tx_beat,
    output logic         tx_valid,
    input  logic         tx_ready
);

    counted_beat_t count_beat;      // masked beat with kept-byte count.
    logic          count_valid;
    logic          count_ready;

    counted_beat_t compact_beat;    // kept bytes in low lanes.
    logic          compact_valid;
    logic          compact_ready;

    stream_pack_count u_count (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_beat  (rx_beat),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_beat  (count_beat),
        .tx_valid (count_valid),
        .tx_ready (count_ready)
    );

    stream_pack_compact u_compact (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_beat  (count_beat),
        .rx_valid (count_valid),
        .rx_ready (count_ready),
        .tx_beat  (compact_beat),
        .tx_valid (compact_valid),
        .tx_ready (compact_ready)
    );

    stream_pack_merge u_merge (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_beat  (compact_beat),
        .rx_valid (compact_valid),
        .rx_ready (compact_ready),
        .tx_beat  (tx_beat),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

endmodule

//--- hdl/stream_pack_merge.sv
// merge stage that accumulates compacted bytes across beats and emits dense output beats.
module stream_pack_merge import stream_pack_pkg::*; (
    input  logic          aclk,
    input  logic          areset_n,
    input  counted_beat_t rx_beat,
    input  logic          rx_valid,
    output logic          rx_ready,
    output stream_beat_t  tx_beat,
    output logic          tx_valid,
    input  logic          tx_ready
);

    logic [residue_bytes-1:0][byte_width-1:0] residue;       // bytes waiting for a full beat.
    logic [count_width-1:0]                   fill;          // valid bytes in residue.
    logic                                     flush_pending; // tail of a tlast beat still owed.

    logic [merge_bytes-1:0][byte_width-1:0]   merged;        // residue then incoming bytes.
    logic [count_width:0]                     total;         // fill plus incoming count.
    logic [count_width-1:0]                   next_fill;
    logic                                     out_free;      // output register can load.
    logic                                     full;          // at least one whole beat.
    logic                                     emit;          // accepted beat produces output.
    logic                                     flush_next;    // tlast beat spills into two beats.

    // output register empties on a handshake or is already empty.
    assign out_free = !tx_valid || tx_ready;

    // no new bytes while the flush beat is still to be loaded.
    assign rx_ready = out_free && !flush_pending;

    assign total      = {1'b0, fill} + {1'b0, rx_beat.count};
    assign full       = (total >= (count_width+1)'(data_bytes));
    assign emit       = full || rx_beat.beat.tlast;             // zero-byte tlast still emits.
    assign flush_next = full && rx_beat.beat.tlast && (total > (count_width+1)'(data_bytes));

    // append incoming bytes right after the residue.
    always_comb begin
        merged = '0;
        for (int j = 0; j < residue_bytes; j++) begin
            if (j < int'(fill)) begin
                merged[j] = residue[j];
            end
        end
        for (int i = 0; i < data_bytes; i++) begin
            if (i < int'(rx_beat.count)) begin
                merged[i + int'(fill)] = rx_beat.beat.tdata[i];
            end
        end
    end

    // fill level after an accepted beat.
    always_comb begin
        if (full) begin
            next_fill = count_width'(total - (count_width+1)'(data_bytes)); // overflow kept.
        end else if (rx_beat.beat.tlast) begin
            next_fill = '0;                                  // everything leaves as last beat.
        end else begin
            next_fill = total[count_width-1:0];
        end
    end

    // control state.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_valid      <= 1'b0;
            fill          <= '0;
            flush_pending <= 1'b0;
        end else if (out_free) begin
            if (flush_pending) begin
                tx_valid      <= 1'b1;                       // second beat of a spilled tlast.
                fill          <= '0;
                flush_pending <= 1'b0;
            end else if (rx_valid) begin
                tx_valid      <= emit;
                fill          <= next_fill;
                flush_pending <= flush_next;
            end else begin
                tx_valid      <= 1'b0;
            end
        end
    end

    // output beat and residue bytes.
    always_ff @(posedge aclk) begin
        if (out_free) begin
            if (flush_pending) begin
                tx_beat.tdata <= {{byte_width{1'b0}}, residue};
                tx_beat.tkeep <= keep_mask(fill);
                tx_beat.tlast <= 1'b1;
            end else if (rx_valid) begin
                tx_beat.tdata <= merged[data_bytes-1:0];
                tx_beat.tkeep <= full ? '1 : keep_mask(total[count_width-1:0]);
                tx_beat.tlast <= rx_beat.beat.tlast && !flush_next; // tlast moves to flush beat.
                if (full) begin
                    residue <= merged[merge_bytes-1:data_bytes];
                end else begin
                    residue <= merged[residue_bytes-1:0];
                end
            end
        end
    end

endmodule

//--- hdl/stream_pack_compact.sv
// registered stage that shifts kept bytes down to the low lanes.
module stream_pack_compact import stream_pack_pkg::*; (
    input  logic          aclk,
    input  logic          areset_n,
    input  counted_beat_t rx_beat,
    input  logic          rx_valid,
    output logic          rx_ready,
    output counted_beat_t tx_beat,
    output logic          tx_valid,
    input  logic          tx_ready
);

    logic [data_bytes-1:0][count_width-1:0] lane_dest;   // target lane of each input lane.
    logic [data_bytes-1:0][byte_width-1:0]  packed_data; // kept bytes moved to the low lanes.

    assign rx_ready = tx_ready;                          // same pass-through as count stage.

    // destination of lane i is the number of kept lanes below it.
    always_comb begin
        lane_dest[0] = '0;
        for (int i = 1; i < data_bytes; i++) begin
            lane_dest[i] = lane_dest[i-1] + {{(count_width-1){1'b0}}, rx_beat.beat.tkeep[i-1]};
        end
    end

    // scatter kept bytes to their destinations in order.
    always_comb begin
        packed_data = '0;
        for (int i = 0; i < data_bytes; i++) begin
            if (rx_beat.beat.tkeep[i]) begin
                packed_data[lane_dest[i]] = rx_beat.beat.tdata[i];
            end
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_valid <= 1'b0;
        end else if (tx_ready) begin
            tx_valid <= rx_valid;
        end
    end

    // tkeep becomes contiguous ones from lane 0 while count and tlast ride along.
    always_ff @(posedge aclk) begin
        if (tx_ready) begin
            tx_beat.beat.tdata <= packed_data;
            tx_beat.beat.tkeep <= keep_mask(rx_beat.count);
            tx_beat.beat.tlast <= rx_beat.beat.tlast;
            tx_beat.count      <= rx_beat.count;
        end
    end

endmodule

//--- hdl/stream_pack_count.sv
// registered stage that zeroes dropped bytes and counts kept bytes.
module stream_pack_count import stream_pack_pkg::*; (
    input  logic          aclk,
    input  logic          areset_n,
    input  stream_beat_t  rx_beat,
    input  logic          rx_valid,
    output logic          rx_ready,
    output counted_beat_t tx_beat,
    output logic          tx_valid,
    input  logic          tx_ready
);

    logic [count_width-1:0]                keep_count;   // kept lanes of rx_beat.
    logic [data_bytes-1:0][byte_width-1:0] masked_data;  // dropped lanes forced to zero.

    // stage advances whenever downstream can take a beat.
    assign rx_ready = tx_ready;

    // population count of tkeep.
    always_comb begin
        keep_count = '0;
        for (int i = 0; i < data_bytes; i++) begin
            if (rx_beat.tkeep[i]) begin
                keep_count = keep_count + 1'b1;
            end
        end
    end

    // null bytes are cleared so no dropped data travels on.
    always_comb begin
        for (int k = 0; k < data_bytes; k++) begin
            masked_data[k] = rx_beat.tkeep[k] ? rx_beat.tdata[k] : '0;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_valid <= 1'b0;
        end else if (tx_ready) begin
            tx_valid <= rx_valid;                        // bubble when nothing arrives.
        end
    end

    // payload register held while downstream stalls.
    always_ff @(posedge aclk) begin
        if (tx_ready) begin
            tx_beat.beat.tdata <= masked_data;
            tx_beat.beat.tkeep <= rx_beat.tkeep;
            tx_beat.beat.tlast <= rx_beat.tlast;
            tx_beat.count      <= keep_count;
        end
    end

endmodule

//--- hdl/stream_pack_pkg.sv
// byte lane localparams, stream beat structs and the tkeep mask helper for the byte packer.
package stream_pack_pkg;

    localparam int byte_width = 8;                     // bits per byte lane.
    localparam int data_bytes = 4;                     // byte lanes per beat.
    localparam int count_width = 3;                    // holds 0 to data_bytes.
    localparam int residue_bytes = data_bytes - 1;     // most bytes left over after a full beat.
    localparam int merge_bytes = 2 * data_bytes - 1;   // residue plus one incoming beat.

    // one AXI4-Stream beat with lane 0 in the low byte.
    typedef struct packed {
        logic [data_bytes-1:0][byte_width-1:0] tdata;  // payload bytes.
        logic [data_bytes-1:0]                 tkeep;  // one bit per lane.
        logic                                  tlast;  // end of packet.
    } stream_beat_t;

    // beat plus the number of kept bytes it carries.
    typedef struct packed {
        stream_beat_t           beat;
        logic [count_width-1:0] count;                 // kept bytes from 0 to data_bytes.
    } counted_beat_t;

    // low-justified tkeep for a given byte count.
    function automatic logic [data_bytes-1:0] keep_mask(
        input logic [count_width-1:0] count
    );
        logic [data_bytes-1:0] mask;

        mask = '0;
        for (int i = 0; i < data_bytes; i++) begin
            mask[i] = (i < int'(count));               // lanes below count are kept.
        end
        return mask;
    endfunction

endpackage
